// File: mem_arbiter_vectors.txt
# op d_address i_address line (256-bit hex, beat 3 first)
# R D-read, I I-read, W D-write, A D-write with D-read and I-read raised together
# The first read entry of an address also sets that line in the memory model
R 00001000 00000000 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0
I 00000000 00002000 a5a5a5a5000000013c3c3c3c000000025a5a5a5a00000003c3c3c3c300000004
R 00001020 00000000 deadbeef00001023cafef00d000010220badc0de00001021feedface00001020
W 00003000 00000000 1000000000000004200000000000000330000000000000024000000000000001
I 00000000 00002040 89abcdef0123456776543210fedcba9813579bdf02468aceeca86420fdb97531
W 00001000 00000000 6666666655555555444444443333333322222222111111110000000099999999
R 00001000 00000000 6666666655555555444444443333333322222222111111110000000099999999
I 00000000 00002000 a5a5a5a5000000013c3c3c3c000000025a5a5a5a00000003c3c3c3c300000004
A 00006000 00002040 77aa77aa77aa77aa00112233445566778899aabbccddeeff7f7f7f7f80808080
W 00001020 00000000 55aa55aa0f0f0f0ff0f0f0f0aa55aa550000000000000000ffffffffffffffff
R 00001020 00000000 55aa55aa0f0f0f0ff0f0f0f0aa55aa550000000000000000ffffffffffffffff
A 00003000 00002000 0123456789abcdeffedcba98765432100f1e2d3c4b5a69788796a5b4c3d2e1f0
I 00000000 00001000 6666666655555555444444443333333322222222111111110000000099999999

// File: compile.f
+incdir+.
mem_arbiter_pkg.sv
req_select.sv
burst_engine.sv
resp_router.sv
mem_arbiter.sv
mem_burst_model.sv
mem_arbiter_asserts.sv
tb_mem_arbiter.sv

// File: tb_mem_arbiter.sv
`include "mem_arbiter_defines.svh"

module tb_mem_arbiter;

	localparam int TIMEOUT_CYCLES = 100;

	logic clk;
	logic reset_n;
	logic d_read_i;
	logic d_write_i;
	logic i_read_i;
	logic [`MA_ADDR_BITS-1:0] d_address_i;
	logic [`MA_ADDR_BITS-1:0] i_address_i;
	mem_arbiter_pkg::cache_line_u d_line_i;
	mem_arbiter_pkg::cache_line_u d_line_o;
	mem_arbiter_pkg::cache_line_u i_line_o;
	logic d_resp_o;
	logic i_resp_o;
	logic stall_o;
	logic mem_resp;
	logic mem_read;
	logic mem_write;
	logic [`MA_ADDR_BITS-1:0] mem_addr;
	logic [`MA_BURST_BITS-1:0] mem_rdata;
	logic [`MA_BURST_BITS-1:0] mem_wdata;
	logic preload;
	logic [`MA_ADDR_BITS-1:0] preload_addr;
	mem_arbiter_pkg::cache_line_u preload_line;
	mem_arbiter_pkg::mem_txn_s last_txn;
	int txn_count;

	int errors;
	int exp_count;
	logic aborted;
	byte vec_op[$];
	logic [`MA_ADDR_BITS-1:0] vec_daddr[$];
	logic [`MA_ADDR_BITS-1:0] vec_iaddr[$];
	mem_arbiter_pkg::cache_line_u vec_line[$];
	// Expected memory contents after the writes in the vectors
	mem_arbiter_pkg::cache_line_u exp_mem [logic [`MA_ADDR_BITS-1:0]];

	mem_arbiter dut0 (
		.clk (clk), .reset_n (reset_n),
		.d_line_i (d_line_i), .d_line_o (d_line_o), .d_address_i (d_address_i),
		.d_read_i (d_read_i), .d_write_i (d_write_i), .d_resp_o (d_resp_o),
		.i_line_o (i_line_o), .i_address_i (i_address_i), .i_read_i (i_read_i),
		.i_resp_o (i_resp_o), .resp_i (mem_resp), .burst_i (mem_rdata),
		.burst_o (mem_wdata), .address_o (mem_addr), .read_o (mem_read),
		.write_o (mem_write), .stall_o (stall_o)
	);

	mem_burst_model mem0 (
		.clk (clk), .reset_n (reset_n),
		.preload_i (preload), .preload_addr_i (preload_addr), .preload_line_i (preload_line),
		.read_i (mem_read), .write_i (mem_write), .address_i (mem_addr),
		.burst_i (mem_wdata), .burst_o (mem_rdata), .resp_o (mem_resp),
		.last_txn_o (last_txn), .txn_count_o (txn_count)
	);

	always #2 clk = ~clk;

	task automatic check_line(input string name, input mem_arbiter_pkg::cache_line_u exp,
			input mem_arbiter_pkg::cache_line_u act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp.word, act.word);
			errors++;
		end
	endtask

	task automatic check_mem_txn(input string name, input mem_arbiter_pkg::mem_txn_s exp,
			input mem_arbiter_pkg::mem_txn_s act);
		if (act !== exp) begin
			$display("Fail %s memory transaction: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act !== exp) begin
			$display("Fail %s memory transaction count: expected %0d, actual %0d",
				name, exp, act);
			errors++;
		end
	endtask

	// Each response follows exactly one new memory transaction
	task automatic count_mem_txn(input string name);
		exp_count++;
		check_count(name, exp_count, txn_count);
	endtask

	function automatic mem_arbiter_pkg::mem_txn_s make_txn(input mem_arbiter_pkg::req_src_e src,
			input logic [`MA_ADDR_BITS-1:0] addr, input mem_arbiter_pkg::cache_line_u line);
		mem_arbiter_pkg::mem_txn_s t;
		t.src = src;
		t.addr = addr;
		t.line = line;
		return t;
	endfunction

	// Vector columns are op, D address, I address and line
	task automatic read_vectors();
		int fd;
		int n;
		string text;
		byte op;
		logic [`MA_ADDR_BITS-1:0] da;
		logic [`MA_ADDR_BITS-1:0] ia;
		logic [`MA_LINE_BITS-1:0] ln;
		fd = $fopen("mem_arbiter_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open mem_arbiter_vectors.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				if (text.len() > 1 && text[0] != "#") begin
					n = $sscanf(text, "%c %h %h %h", op, da, ia, ln);
					if (n == 4) begin
						vec_op.push_back(op);
						vec_daddr.push_back(da);
						vec_iaddr.push_back(ia);
						vec_line.push_back(ln);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// First read entry of each address gives the memory's initial line
	task automatic preload_model();
		logic [`MA_ADDR_BITS-1:0] addr;
		for (int i = 0; i < vec_op.size(); i++) begin
			addr = (vec_op[i] == "I") ? vec_iaddr[i] : vec_daddr[i];
			if ((vec_op[i] == "R" || vec_op[i] == "I") && !exp_mem.exists(addr)) begin
				exp_mem[addr] = vec_line[i];
				@(posedge clk);
				preload <= 1'b1;
				preload_addr <= addr;
				preload_line <= vec_line[i];
			end
		end
		@(posedge clk);
		preload <= 1'b0;
	endtask

	task automatic await_resp(input string name, input logic icache, output logic ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			check_level({name, " stall_o"}, 1'b1, stall_o);
			check_level({name, " other response"}, 1'b0, icache ? d_resp_o : i_resp_o);
			ok = icache ? i_resp_o : d_resp_o;
			cycles++;
		end
		if (!ok) begin
			$display("Timeout: a response never arrived for test %s", name);
			errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic finish_check(input string name);
		@(negedge clk);
		check_level({name, " stall_o after"}, 1'b0, stall_o);
		check_level({name, " d_resp_o after"}, 1'b0, d_resp_o);
		check_level({name, " i_resp_o after"}, 1'b0, i_resp_o);
	endtask

	task automatic single_txn(input string name, input byte op, input logic [31:0] da,
			input logic [31:0] ia, input mem_arbiter_pkg::cache_line_u line);
		logic ok;
		@(posedge clk);
		d_address_i <= da;
		i_address_i <= ia;
		d_line_i <= line;
		d_read_i <= (op == "R");
		d_write_i <= (op == "W");
		i_read_i <= (op == "I");
		await_resp(name, op == "I", ok);
		if (ok) begin
			count_mem_txn(name);
		end
		if (ok && op == "W") begin
			exp_mem[da] = line;
			check_mem_txn(name, make_txn(mem_arbiter_pkg::SRC_DWRITE, da, line), last_txn);
		end else if (ok) begin
			check_line(name, line, (op == "I") ? i_line_o : d_line_o);
			check_mem_txn(name, make_txn(mem_arbiter_pkg::SRC_DREAD,
				(op == "I") ? ia : da, line), last_txn);
		end
		@(posedge clk);
		d_read_i <= 1'b0;
		d_write_i <= 1'b0;
		i_read_i <= 1'b0;
		finish_check(name);
	endtask

	// D-write, D-read and I-read raised in the same cycle
	task automatic all_txn(input string name, input logic [31:0] da, input logic [31:0] ia,
			input mem_arbiter_pkg::cache_line_u line);
		logic ok;
		mem_arbiter_pkg::cache_line_u exp_i;
		exp_i = exp_mem[ia];
		exp_mem[da] = line;
		@(posedge clk);
		d_address_i <= da;
		i_address_i <= ia;
		d_line_i <= line;
		d_write_i <= 1'b1;
		d_read_i <= 1'b1;
		i_read_i <= 1'b1;
		await_resp({name, " write"}, 1'b0, ok);
		if (ok) begin
			count_mem_txn({name, " write"});
			check_mem_txn({name, " write"},
				make_txn(mem_arbiter_pkg::SRC_DWRITE, da, line), last_txn);
		end
		@(posedge clk);
		d_write_i <= 1'b0;
		await_resp({name, " d-read"}, 1'b0, ok);
		if (ok) begin
			count_mem_txn({name, " d-read"});
			check_line({name, " d-read"}, line, d_line_o);
			check_mem_txn({name, " d-read"},
				make_txn(mem_arbiter_pkg::SRC_DREAD, da, line), last_txn);
		end
		@(posedge clk);
		d_read_i <= 1'b0;
		await_resp({name, " i-read"}, 1'b1, ok);
		if (ok) begin
			count_mem_txn({name, " i-read"});
			check_line({name, " i-read"}, exp_i, i_line_o);
			check_mem_txn({name, " i-read"},
				make_txn(mem_arbiter_pkg::SRC_DREAD, ia, exp_i), last_txn);
		end
		@(posedge clk);
		i_read_i <= 1'b0;
		finish_check(name);
	endtask

	initial begin
		string name;
		errors = 0;
		exp_count = 0;
		aborted = 1'b0;
		void'($urandom(32'h5f3932f7));
		clk = 1'b0;
		reset_n = 1'b1;
		d_read_i = 1'b0;
		d_write_i = 1'b0;
		i_read_i = 1'b0;
		d_address_i = '0;
		i_address_i = '0;
		d_line_i = '0;
		preload = 1'b0;
		preload_addr = '0;
		preload_line = '0;
		read_vectors();
		repeat (4) @(posedge clk);
		reset_n <= 1'b0;
		@(negedge clk);
		check_level("reset read_o", 1'b0, mem_read);
		check_level("reset write_o", 1'b0, mem_write);
		check_level("reset d_resp_o", 1'b0, d_resp_o);
		check_level("reset i_resp_o", 1'b0, i_resp_o);
		check_level("reset stall_o", 1'b0, stall_o);
		preload_model();
		for (int i = 0; i < vec_op.size() && !aborted; i++) begin
			name = $sformatf("vector %0d (%c)", i, vec_op[i]);
			if (vec_op[i] == "A") begin
				all_txn(name, vec_daddr[i], vec_iaddr[i], vec_line[i]);
			end else if (vec_op[i] == "R" || vec_op[i] == "W" || vec_op[i] == "I") begin
				single_txn(name, vec_op[i], vec_daddr[i], vec_iaddr[i], vec_line[i]);
			end else begin
				$display("Unknown operation in %s", name);
				errors++;
			end
		end
		$display("Error count: %0d check(s), %0d assertion(s)",
			errors, dut0.u_asserts.fail_count);
		if (errors == 0 && dut0.u_asserts.fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule : tb_mem_arbiter

// File: mem_arbiter_asserts.sv
`include "mem_arbiter_defines.svh"

module mem_arbiter_asserts (
	input  logic clk,
	input  logic reset_n,
	input  logic read_i,
	input  logic write_i,
	input  logic d_resp_i,
	input  logic i_resp_i,
	input  logic stall_i,
	input  logic [`MA_ADDR_BITS-1:0] address_i
);

	int fail_count = 0;

	// Direction holds from beat 0 until the response pulse
	rw_held: assert property (@(posedge clk) disable iff (reset_n)
		(read_i || write_i) |=> ($stable({read_i, write_i}) || d_resp_i || i_resp_i))
		else begin
			fail_count++;
			$error("read_o or write_o changed before the response pulse");
		end

	resp_one_cycle: assert property (@(posedge clk) disable iff (reset_n)
		(d_resp_i || i_resp_i) |=> !(d_resp_i || i_resp_i))
		else begin
			fail_count++;
			$error("a response pulse lasted more than one cycle");
		end

	// Line address holds for the whole burst
	addr_stable: assert property (@(posedge clk) disable iff (reset_n)
		(read_i || write_i) |=> (!(read_i || write_i) || $stable(address_i)))
		else begin
			fail_count++;
			$error("address_o changed during a burst");
		end

	stall_on_resp: assert property (@(posedge clk) disable iff (reset_n)
		(d_resp_i || i_resp_i) |-> stall_i)
		else begin
			fail_count++;
			$error("stall_o is low during a response pulse");
		end

endmodule : mem_arbiter_asserts

bind mem_arbiter mem_arbiter_asserts u_asserts (
	.clk       (clk),
	.reset_n   (reset_n),
	.read_i    (read_o),
	.write_i   (write_o),
	.d_resp_i  (d_resp_o),
	.i_resp_i  (i_resp_o),
	.stall_i   (stall_o),
	.address_i (address_o)
);

// File: mem_burst_model.sv
`include "mem_arbiter_defines.svh"

module mem_burst_model (
	input  logic clk,
	input  logic reset_n,

	// Preload port, used before any traffic
	input  logic preload_i,
	input  logic [`MA_ADDR_BITS-1:0] preload_addr_i,
	input  mem_arbiter_pkg::cache_line_u preload_line_i,

	// Memory side of the arbiter
	input  logic read_i,
	input  logic write_i,
	input  logic [`MA_ADDR_BITS-1:0] address_i,
	input  logic [`MA_BURST_BITS-1:0] burst_i,
	output logic [`MA_BURST_BITS-1:0] burst_o,
	output logic resp_o,

	// Last finished transaction; the memory cannot tell the caches apart,
	// so every read is logged as SRC_DREAD
	output mem_arbiter_pkg::mem_txn_s last_txn_o,
	output int txn_count_o
);

	mem_arbiter_pkg::cache_line_u mem [logic [`MA_ADDR_BITS-1:0]];
	mem_arbiter_pkg::cache_line_u cur;
	logic busy;
	int beat;
	int wait_left;

	always @(posedge clk) begin
		if (preload_i) begin
			mem[preload_addr_i] = preload_line_i;
		end
		if (reset_n) begin
			busy = 1'b0;
			beat = 0;
			wait_left = 0;
			resp_o <= 1'b0;
			burst_o <= '0;
			last_txn_o <= '0;
			txn_count_o <= 0;
		end else if (read_i || write_i) begin
			if (!busy) begin
				busy = 1'b1;
				beat = 0;
				wait_left = $urandom % 4;
				cur.word = '0;
				for (int k = 0; k < `MA_BEATS; k++) begin
					// Unwritten lines read back a pattern made from the address
					if (read_i) cur.beats[k] = {address_i, address_i ^ 32'(k)};
				end
				if (read_i && mem.exists(address_i)) cur = mem[address_i];
			end else if (resp_o) begin
				if (write_i) cur.beats[beat] = burst_i;
				beat++;
				wait_left = $urandom % 4;
			end
			if (beat == `MA_BEATS) begin
				if (write_i) mem[address_i] = cur;
				last_txn_o.src <= write_i ? mem_arbiter_pkg::SRC_DWRITE : mem_arbiter_pkg::SRC_DREAD;
				last_txn_o.addr <= address_i;
				last_txn_o.line <= cur;
				txn_count_o <= txn_count_o + 1;
				busy = 1'b0;
				resp_o <= 1'b0;
				burst_o <= '0;
			end else if (wait_left == 0) begin
				resp_o <= 1'b1;
				burst_o <= write_i ? '0 : cur.beats[beat];
			end else begin
				wait_left--;
				resp_o <= 1'b0;
			end
		end else begin
			resp_o <= 1'b0;
		end
	end

endmodule : mem_burst_model

// File: mem_arbiter.sv
`include "mem_arbiter_defines.svh"

module mem_arbiter (
	input  logic clk,
	input  logic reset_n,

	// Data cache
	input  mem_arbiter_pkg::cache_line_u d_line_i,
	output mem_arbiter_pkg::cache_line_u d_line_o,
	input  logic [`MA_ADDR_BITS-1:0] d_address_i,
	input  logic d_read_i,
	input  logic d_write_i,
	output logic d_resp_o,

	// Instruction cache
	output mem_arbiter_pkg::cache_line_u i_line_o,
	input  logic [`MA_ADDR_BITS-1:0] i_address_i,
	input  logic i_read_i,
	output logic i_resp_o,

	// Burst memory
	input  logic resp_i,
	input  logic [`MA_BURST_BITS-1:0] burst_i,
	output logic [`MA_BURST_BITS-1:0] burst_o,
	output logic [`MA_ADDR_BITS-1:0] address_o,
	output logic read_o,
	output logic write_o,

	// CPU
	output logic stall_o
);

	logic txn_valid;
	logic done;
	logic release_txn;
	mem_arbiter_pkg::mem_txn_s sel_txn;
	mem_arbiter_pkg::mem_txn_s eng_txn;

	req_select u_select (
		.clk         (clk),
		.reset_n     (reset_n),
		.d_read_i    (d_read_i),
		.d_write_i   (d_write_i),
		.i_read_i    (i_read_i),
		.d_address_i (d_address_i),
		.i_address_i (i_address_i),
		.d_line_i    (d_line_i),
		.release_i   (release_txn),
		.txn_valid_o (txn_valid),
		.txn_o       (sel_txn),
		.stall_o     (stall_o)
	);

	burst_engine u_engine (
		.clk         (clk),
		.reset_n     (reset_n),
		.txn_valid_i (txn_valid),
		.txn_i       (sel_txn),
		.resp_i      (resp_i),
		.burst_i     (burst_i),
		.burst_o     (burst_o),
		.address_o   (address_o),
		.read_o      (read_o),
		.write_o     (write_o),
		.done_o      (done),
		.txn_o       (eng_txn)
	);

	resp_router u_router (
		.clk       (clk),
		.reset_n   (reset_n),
		.done_i    (done),
		.txn_i     (eng_txn),
		.d_line_o  (d_line_o),
		.i_line_o  (i_line_o),
		.d_resp_o  (d_resp_o),
		.i_resp_o  (i_resp_o),
		.release_o (release_txn)
	);

endmodule : mem_arbiter

// File: resp_router.sv
`include "mem_arbiter_defines.svh"

module resp_router (
	input  logic clk,
	input  logic reset_n,

	// Completed transaction from the burst engine
	input  logic done_i,
	input  mem_arbiter_pkg::mem_txn_s txn_i,

	// Cache side
	output mem_arbiter_pkg::cache_line_u d_line_o,
	output mem_arbiter_pkg::cache_line_u i_line_o,
	output logic d_resp_o,
	output logic i_resp_o,

	// Back to the select stage
	output logic release_o
);

	logic to_icache;

	assign to_icache = (txn_i.src == mem_arbiter_pkg::SRC_IREAD);

	// One-cycle pulses starting at the edge of the last beat
	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			d_resp_o <= 1'b0;
			i_resp_o <= 1'b0;
			release_o <= 1'b0;
		end else begin
			d_resp_o <= done_i && !to_icache;
			i_resp_o <= done_i && to_icache;
			release_o <= done_i;
		end
	end

	// Lines stay on the outputs after the pulse
	always_ff @(posedge clk) begin
		if (done_i && txn_i.src == mem_arbiter_pkg::SRC_DREAD) begin
			d_line_o <= txn_i.line;
		end
		if (done_i && to_icache) begin
			i_line_o <= txn_i.line;
		end
	end

endmodule : resp_router

// File: burst_engine.sv
`include "mem_arbiter_defines.svh"

module burst_engine (
	input  logic clk,
	input  logic reset_n,

	// Held transaction from the select stage
	input  logic txn_valid_i,
	input  mem_arbiter_pkg::mem_txn_s txn_i,

	// Memory port
	input  logic resp_i,
	input  logic [`MA_BURST_BITS-1:0] burst_i,
	output logic [`MA_BURST_BITS-1:0] burst_o,
	output logic [`MA_ADDR_BITS-1:0] address_o,
	output logic read_o,
	output logic write_o,

	// Completed transaction to the router
	output logic done_o,
	output mem_arbiter_pkg::mem_txn_s txn_o
);

	localparam int BEAT_BITS = $clog2(`MA_BEATS);
	localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(`MA_BEATS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BEAT,
		ST_DONE
	} state_e;

	state_e state_q;
	logic [BEAT_BITS-1:0] beat_q;
	logic active;
	logic is_write;
	logic beat_done;
	mem_arbiter_pkg::cache_line_u rd_line_q;
	mem_arbiter_pkg::cache_line_u rd_line;

	// A new transaction drives the port in the first cycle it is held
	assign active = (state_q == ST_BEAT) || (state_q == ST_IDLE && txn_valid_i);
	assign is_write = (txn_i.src == mem_arbiter_pkg::SRC_DWRITE);
	assign beat_done = active && resp_i;

	assign read_o = active && !is_write;
	assign write_o = active && is_write;
	assign address_o = active ? txn_i.addr : '0;
	assign burst_o = write_o ? txn_i.line.beats[beat_q] : '0;

	// Last beat completes in this cycle
	assign done_o = beat_done && (beat_q == LAST_BEAT);

	// Read line with the beat on burst_i merged in
	always_comb begin
		rd_line = rd_line_q;
		rd_line.beats[beat_q] = burst_i;
	end

	always_comb begin
		txn_o = txn_i;
		if (!is_write) begin
			txn_o.line = rd_line;
		end
	end

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			state_q <= ST_IDLE;
			beat_q <= '0;
		end else begin
			if (beat_done) begin
				// Counter wraps back to beat 0 after the last beat
				beat_q <= beat_q + 1'b1;
			end
			case (state_q)
				ST_IDLE: begin
					if (txn_valid_i) begin
						state_q <= ST_BEAT;
					end
				end
				ST_BEAT: begin
					if (done_o) begin
						state_q <= ST_DONE;
					end
				end
				ST_DONE: begin
					// Wait for the select stage to drop the served transaction
					if (!txn_valid_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Gather read beats
	always_ff @(posedge clk) begin
		if (read_o && resp_i) begin
			rd_line_q <= rd_line;
		end
	end

endmodule : burst_engine

// File: req_select.sv
`include "mem_arbiter_defines.svh"

module req_select (
	input  logic clk,
	input  logic reset_n,

	// Cache request levels
	input  logic d_read_i,
	input  logic d_write_i,
	input  logic i_read_i,
	input  logic [`MA_ADDR_BITS-1:0] d_address_i,
	input  logic [`MA_ADDR_BITS-1:0] i_address_i,
	input  mem_arbiter_pkg::cache_line_u d_line_i,

	// From the response router
	input  logic release_i,

	// To the burst engine
	output logic txn_valid_o,
	output mem_arbiter_pkg::mem_txn_s txn_o,

	// To the CPU
	output logic stall_o
);

	logic held_q;
	logic any_req;
	logic take;
	mem_arbiter_pkg::mem_txn_s pick;
	mem_arbiter_pkg::mem_txn_s txn_q;

	assign any_req = d_write_i || d_read_i || i_read_i;

	// Only latch when nothing is held; requests during the release cycle are ignored
	assign take = !held_q && any_req;

	// D-write wins over D-read, which wins over I-read
	always_comb begin
		pick.src = mem_arbiter_pkg::SRC_IREAD;
		pick.addr = i_address_i;
		pick.line.word = '0;
		if (d_write_i) begin
			pick.src = mem_arbiter_pkg::SRC_DWRITE;
			pick.addr = d_address_i;
			pick.line.word = d_line_i.word;
		end else if (d_read_i) begin
			pick.src = mem_arbiter_pkg::SRC_DREAD;
			pick.addr = d_address_i;
		end
	end

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			held_q <= 1'b0;
		end else if (release_i) begin
			held_q <= 1'b0;
		end else if (take) begin
			held_q <= 1'b1;
		end
	end

	// Transaction payload, stable until release
	always_ff @(posedge clk) begin
		if (take) begin
			txn_q <= pick;
		end
	end

	assign txn_valid_o = held_q;
	assign txn_o = txn_q;

	// Stall as soon as a request shows up, not only once it is latched
	assign stall_o = any_req || held_q;

endmodule : req_select

// File: mem_arbiter_pkg.sv
`include "mem_arbiter_defines.svh"

package mem_arbiter_pkg;

	// One cache line as a flat word or as beats with beat 0 in the low bits
	typedef union packed {
		logic [`MA_LINE_BITS-1:0] word;
		logic [`MA_BEATS-1:0][`MA_BURST_BITS-1:0] beats;
	} cache_line_u;

	// Which cache and which operation a transaction serves
	typedef enum logic [1:0] {
		SRC_DREAD,
		SRC_DWRITE,
		SRC_IREAD
	} req_src_e;

	// One memory transaction as it moves between the stages
	typedef struct packed {
		req_src_e src;
		logic [`MA_ADDR_BITS-1:0] addr;
		cache_line_u line;
	} mem_txn_s;

endpackage : mem_arbiter_pkg

// File: mem_arbiter_defines.svh
`ifndef MEM_ARBITER_DEFINES_SVH
`define MEM_ARBITER_DEFINES_SVH

// Cache line width in bits
`define MA_LINE_BITS 256

// Width of one memory beat
`define MA_BURST_BITS 64

// Beats per cache line
`define MA_BEATS 4

// Byte address width on both cache ports and the memory port
`define MA_ADDR_BITS 32

`endif
